// File: files.f
verilog/read_datapath_pkg.sv
verilog/read_latency_fifo.sv
verilog/read_fifo_group.sv
verilog/oct_control.sv
verilog/read_datapath.sv
testbench/tb_clock_gen.sv
testbench/tb_read_datapath.sv

// File: run.sh
#!/bin/sh
# Builds the read datapath testbench with Verilator and runs it.
# The exit status is the simulator's: nonzero when the test fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_read_datapath -Mdir obj_dir -o tb_read_datapath -f files.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_read_datapath
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi

exit 0

// File: testbench/tb_clock_gen.sv
/*
 * Clock and reset source for the read datapath testbench. Runs a 10 ns
 * pll_afi_clk and holds reset low for the first 8 cycles.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic pll_afi_clk_o,
	output logic reset_n_afi_clk_o
);

	localparam int HALF_PERIOD_NS = 5;
	localparam int RESET_CYCLES = 8;

	initial
	begin
		pll_afi_clk_o = 1'b0;
		forever
			#HALF_PERIOD_NS pll_afi_clk_o = ~pll_afi_clk_o;
	end

	// Release lands on a falling edge, half a cycle away from the sampling edge
	initial
	begin
		reset_n_afi_clk_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge pll_afi_clk_o);
		@(negedge pll_afi_clk_o);
		reset_n_afi_clk_o = 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/tb_read_datapath.sv
/*
 * Testbench for the read datapath. Drives random enables, latency counts,
 * DDIO words and group FIFO resets, and checks every cycle against a model.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_read_datapath;

	import read_datapath_pkg::*;

	localparam logic [31:0] LCG_SEED = 32'h7872db41;
	localparam int CLK_PERIOD_NS = 10;
	localparam int RESET_CYCLES = 8;
	localparam int IDLE_CYCLES = 24;
	localparam int NUM_PHASES = 6;
	localparam int PHASE_CYCLES = 200;
	localparam int DRAIN_CYCLES = 40;
	localparam int TOTAL_CYCLES =
		RESET_CYCLES + IDLE_CYCLES + NUM_PHASES * (PHASE_CYCLES + DRAIN_CYCLES);
	// Termination stays on for six edges after each sampled full enable
	localparam int OCT_WINDOW_CYCLES = 6;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	logic afi_rdata_en;
	logic afi_rdata_en_full;
	latency_count_t seq_read_latency_counter;
	dqs_mask_t seq_read_fifo_reset;
	afi_data_t ddio_phy_dq;
	afi_data_t afi_rdata;
	afi_phase_t afi_rdata_valid;
	logic force_oct_off;

	// Stimulus state
	logic [31:0] lcg_state;
	latency_count_t phase_latency;
	dqs_mask_t reset_group;
	int reset_hold;

	// Model state, updated on every rising edge after reset
	int cycle_count;
	int valid_due [$];
	int pop_due [$];
	logic model_ws_n [MEM_READ_DQS_WIDTH];
	fifo_addr_t model_wr [MEM_READ_DQS_WIDTH];
	fifo_addr_t model_rd [MEM_READ_DQS_WIDTH];
	group_data_t model_mem [MEM_READ_DQS_WIDTH][READ_FIFO_DEPTH];
	group_data_t model_out [MEM_READ_DQS_WIDTH];
	// Cycle of the most recent sampled full enable
	int last_full_en;
	afi_phase_t exp_valid;
	logic exp_force_off;

	tb_clock_gen i_tb_clock_gen (
		.pll_afi_clk_o(pll_afi_clk),
		.reset_n_afi_clk_o(reset_n_afi_clk)
	);

	read_datapath i_read_datapath (
		.pll_afi_clk(pll_afi_clk),
		.reset_n_afi_clk(reset_n_afi_clk),
		.afi_rdata_en_i(afi_rdata_en),
		.afi_rdata_en_full_i(afi_rdata_en_full),
		.seq_read_latency_counter_i(seq_read_latency_counter),
		.seq_read_fifo_reset_i(seq_read_fifo_reset),
		.ddio_phy_dq_i(ddio_phy_dq),
		.afi_rdata_o(afi_rdata),
		.afi_rdata_valid_o(afi_rdata_valid),
		.force_oct_off_o(force_oct_off)
	);

	// **************************************************
	// Random numbers and reporting
	// **************************************************

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("FAIL %s at cycle %0d: expected %h, actual %h",
				name, cycle_count, expected, actual);
			stop_with_failure("A check failed, stopping at the first failure");
		end
	endtask

	// **************************************************
	// Reference model
	// **************************************************

	// Group-major FIFO words laid out timeslot-major, as on the AFI bus
	function automatic afi_data_t expected_rdata();
		afi_data_t word;
		word = '0;
		for (int g = 0; g < MEM_READ_DQS_WIDTH; g++)
			for (int t = 0; t < NUM_TIMESLOTS; t++)
				word[t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
					model_out[g][t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
		return word;
	endfunction

	task automatic update_model();
		logic pop;
		logic valid;
		group_data_t data;
		pop = 1'b0;
		valid = 1'b0;
		// Enables come due L+2 edges after they were sampled
		if (pop_due.size() > 0 && pop_due[0] == cycle_count)
		begin
			pop = 1'b1;
			void'(pop_due.pop_front());
		end
		if (valid_due.size() > 0 && valid_due[0] == cycle_count)
		begin
			valid = 1'b1;
			void'(valid_due.pop_front());
		end
		for (int g = 0; g < MEM_READ_DQS_WIDTH; g++)
		begin
			data = ddio_phy_dq[g*GROUP_DATA_WIDTH +: GROUP_DATA_WIDTH];
			// A pop sees the storage as it was before this edge's write
			if (pop)
				model_out[g] = model_mem[g][model_rd[g]];
			if (seq_read_fifo_reset[g])
				model_rd[g] = '0;
			else if (pop)
				model_rd[g] = model_rd[g] + 1'b1;
			if (model_ws_n[g])
			begin
				model_mem[g][model_wr[g]] = data;
				model_wr[g] = model_wr[g] + 1'b1;
			end
			else
			begin
				model_mem[g][0] = data;
				model_wr[g] = '0;
			end
			model_ws_n[g] = ~seq_read_fifo_reset[g];
		end
		exp_valid = {AFI_RATE_RATIO{valid}};
		// Termination is forced off unless a full enable was sampled
		// within the last six edges before this one
		exp_force_off = (cycle_count - last_full_en > OCT_WINDOW_CYCLES);
		if (afi_rdata_en_full)
			last_full_en = cycle_count;
		if (afi_rdata_en)
			valid_due.push_back(cycle_count + int'(seq_read_latency_counter) + 2);
		if (afi_rdata_en_full)
			pop_due.push_back(cycle_count + int'(seq_read_latency_counter) + 2);
		cycle_count = cycle_count + 1;
	endtask

	// **************************************************
	// Stimulus and per-cycle checks
	// **************************************************

	task automatic drive_inputs(input logic active);
		logic [31:0] rnd;
		rnd = next_random();
		afi_rdata_en_full = active && (rnd[31:29] < 3'd3);
		// The data enable mostly follows the full enable, but not always
		afi_rdata_en = (rnd[28:26] == 3'd0) ? (active && !afi_rdata_en_full)
			: afi_rdata_en_full;
		ddio_phy_dq = next_random();
		if (reset_hold == 0 && active && rnd[22:17] == 6'd0)
		begin
			// Pulse one group only, for one to four cycles
			reset_group = rnd[16] ? 2'b10 : 2'b01;
			reset_hold = 1 + int'(rnd[15:14]);
		end
		if (reset_hold > 0)
		begin
			seq_read_fifo_reset = reset_group;
			reset_hold = reset_hold - 1;
		end
		else
			seq_read_fifo_reset = '0;
		seq_read_latency_counter = phase_latency;
	endtask

	// Starts and ends just after a rising edge
	task automatic clock_cycle(input logic active);
		update_model();
		@(negedge pll_afi_clk);
		check_value("read latency valid", 32'(exp_valid), 32'(afi_rdata_valid));
		check_value("read data order", expected_rdata(), afi_rdata);
		check_value("oct window", 32'(exp_force_off), 32'(force_oct_off));
		drive_inputs(active);
		@(posedge pll_afi_clk);
	endtask

	initial
	begin
		logic [31:0] rnd;
		afi_rdata_en = 1'b0;
		afi_rdata_en_full = 1'b0;
		seq_read_latency_counter = '0;
		seq_read_fifo_reset = '0;
		ddio_phy_dq = '0;
		lcg_state = LCG_SEED;
		phase_latency = '0;
		reset_group = '0;
		reset_hold = 0;
		cycle_count = 0;
		for (int g = 0; g < MEM_READ_DQS_WIDTH; g++)
		begin
			model_ws_n[g] = 1'b0;
			model_wr[g] = '0;
			model_rd[g] = '0;
			model_out[g] = '0;
			for (int e = 0; e < READ_FIFO_DEPTH; e++)
				model_mem[g][e] = '0;
		end
		last_full_en = -OCT_WINDOW_CYCLES - 1;
		exp_valid = '0;
		exp_force_off = 1'b0;

		// Valid and force-off hold 0 for the whole reset
		@(posedge pll_afi_clk);
		while (reset_n_afi_clk !== 1'b1)
		begin
			check_value("reset valid", 32'd0, 32'(afi_rdata_valid));
			check_value("reset oct", 32'd0, 32'(force_oct_off));
			@(posedge pll_afi_clk);
		end

		// Every FIFO entry is written before the first pop can reach it
		repeat (IDLE_CYCLES) clock_cycle(1'b0);

		for (int phase = 0; phase < NUM_PHASES; phase++)
		begin
			rnd = next_random();
			// First two phases cover the shortest and longest latency
			if (phase == 0)
				phase_latency = '0;
			else if (phase == 1)
				phase_latency = '1;
			else
				phase_latency = rnd[31:27];
			repeat (PHASE_CYCLES) clock_cycle(1'b1);
			// Empty the enable pipeline before the latency count moves
			repeat (DRAIN_CYCLES) clock_cycle(1'b0);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

	initial
	begin
		#(2 * TOTAL_CYCLES * CLK_PERIOD_NS);
		stop_with_failure("Timeout: the test sequence did not finish in time");
	end

endmodule

`default_nettype wire

// File: verilog/oct_control.sv
/*
 * Keeps on-die termination enabled around each read burst by dropping
 * the force-off for a window after every full-rate read enable.
 */

`timescale 1ns/1ps
`default_nettype none

module oct_control (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire afi_rdata_en_full_i,
	output logic force_oct_off_o
);

	import read_datapath_pkg::*;

	// Bit n holds the enable sampled n+1 edges before the current one
	logic [OCT_OFF_DELAY-1:0] rdata_en_hist;

	// **************************************************
	// Read enable history and force-off window
	// **************************************************

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_hist <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			rdata_en_hist <= {rdata_en_hist[OCT_OFF_DELAY-2:0], afi_rdata_en_full_i};
			// Termination stays on while any enable from OCT_ON_DELAY to
			// OCT_OFF_DELAY cycles back is still in the history
			force_oct_off_o <= ~(|rdata_en_hist[OCT_OFF_DELAY-1:OCT_ON_DELAY-1]);
		end
	end

endmodule

`default_nettype wire

// File: verilog/read_datapath.sv
/*
 * Top of the AFI-side read datapath. Delays the controller's read enables,
 * pops one data FIFO per DQS group and returns timeslot-major data on AFI.
 */

`timescale 1ns/1ps
`default_nettype none

module read_datapath (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire afi_rdata_en_i,
	input wire afi_rdata_en_full_i,
	input wire read_datapath_pkg::latency_count_t seq_read_latency_counter_i,
	input wire read_datapath_pkg::dqs_mask_t seq_read_fifo_reset_i,
	input wire read_datapath_pkg::afi_data_t ddio_phy_dq_i,
	output read_datapath_pkg::afi_data_t afi_rdata_o,
	output read_datapath_pkg::afi_phase_t afi_rdata_valid_o,
	output logic force_oct_off_o
);

	import read_datapath_pkg::*;

	// FIFO pop strobe, shared by every DQS group
	logic read_enable;

	// **************************************************
	// Latency FIFO
	// **************************************************

	read_latency_fifo i_read_latency_fifo (
		.pll_afi_clk(pll_afi_clk),
		.reset_n_afi_clk(reset_n_afi_clk),
		.afi_rdata_en_i(afi_rdata_en_i),
		.afi_rdata_en_full_i(afi_rdata_en_full_i),
		.latency_count_i(seq_read_latency_counter_i),
		.read_enable_o(read_enable),
		.afi_rdata_valid_o(afi_rdata_valid_o)
	);

	// **************************************************
	// Per-group read FIFOs and data remap
	// **************************************************

	for (genvar g = 0; g < MEM_READ_DQS_WIDTH; g++)
	begin : g_group
		group_data_t capture_data;
		group_data_t group_rdata;

		// DDIO bus is group-major, so a group's word is one contiguous slice
		assign capture_data = ddio_phy_dq_i[g*GROUP_DATA_WIDTH +: GROUP_DATA_WIDTH];

		read_fifo_group i_read_fifo_group (
			.pll_afi_clk(pll_afi_clk),
			.reset_n_afi_clk(reset_n_afi_clk),
			.seq_read_fifo_reset_i(seq_read_fifo_reset_i[g]),
			.read_enable_i(read_enable),
			.capture_data_i(capture_data),
			.read_data_o(group_rdata)
		);

		// AFI bus is timeslot-major, so each nibble of the group word is
		// spread out to its own timeslot lane
		for (genvar t = 0; t < NUM_TIMESLOTS; t++)
		begin : g_timeslot
			assign afi_rdata_o[t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				group_rdata[t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
		end
	end

	// **************************************************
	// OCT control
	// **************************************************

	oct_control i_oct_control (
		.pll_afi_clk(pll_afi_clk),
		.reset_n_afi_clk(reset_n_afi_clk),
		.afi_rdata_en_full_i(afi_rdata_en_full_i),
		.force_oct_off_o(force_oct_off_o)
	);

endmodule

`default_nettype wire

// File: verilog/read_datapath_pkg.sv
/*
 * Shared widths, depths, latency limits and OCT timing for the half-rate
 * DDR2 read datapath. Modules import it to size their buses and storage.
 */

`default_nettype none

package read_datapath_pkg;

	// Memory side of the interface
	localparam int MEM_DQ_WIDTH = 8;
	localparam int MEM_READ_DQS_WIDTH = 2;
	localparam int DQ_GROUP_WIDTH = MEM_DQ_WIDTH / MEM_READ_DQS_WIDTH;

	// Half rate gives four DQ beats and two AFI phases per AFI cycle
	localparam int NUM_TIMESLOTS = 4;
	localparam int AFI_RATE_RATIO = 2;
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * NUM_TIMESLOTS;
	localparam int GROUP_DATA_WIDTH = DQ_GROUP_WIDTH * NUM_TIMESLOTS;

	// Per-group read FIFO
	localparam int READ_FIFO_DEPTH = 16;
	localparam int READ_FIFO_ADDR_WIDTH = 4;

	// Latency FIFO, one shift stage per AFI cycle of read latency
	localparam int MAX_READ_LATENCY = 32;
	localparam int LATENCY_COUNT_WIDTH = 5;

	// OCT window in AFI cycles, taken from the memory read latency in memory clocks
	localparam int MEM_T_RL = 6;
	localparam int OCT_ON_DELAY = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// Full AFI or DDIO data word
	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;
	// One DQS group's share of a word, ordered by timeslot
	typedef logic [GROUP_DATA_WIDTH-1:0] group_data_t;
	typedef logic [READ_FIFO_ADDR_WIDTH-1:0] fifo_addr_t;
	typedef logic [LATENCY_COUNT_WIDTH-1:0] latency_count_t;
	// One bit per DQS group
	typedef logic [MEM_READ_DQS_WIDTH-1:0] dqs_mask_t;
	// One bit per AFI phase
	typedef logic [AFI_RATE_RATIO-1:0] afi_phase_t;

endpackage

`default_nettype wire

// File: verilog/read_fifo_group.sv
/*
 * Data FIFO for one DQS group. Capture words are written every cycle and
 * popped by the latency FIFO's read enable through a registered output.
 */

`timescale 1ns/1ps
`default_nettype none

module read_fifo_group (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire seq_read_fifo_reset_i,
	input wire read_enable_i,
	input wire read_datapath_pkg::group_data_t capture_data_i,
	output read_datapath_pkg::group_data_t read_data_o
);

	import read_datapath_pkg::*;

	// Write-side reset, active low, comes up active out of system reset
	logic reset_n_write_side;
	fifo_addr_t wr_ptr;
	fifo_addr_t wr_addr;
	fifo_addr_t rd_ptr;
	group_data_t fifo_mem [READ_FIFO_DEPTH];

	// **************************************************
	// Write side
	// **************************************************

	// The sequencer's reset request is registered once before it reaches
	// the write pointer, as the capture logic would see it
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			reset_n_write_side <= 1'b0;
		else
			reset_n_write_side <= ~seq_read_fifo_reset_i;
	end

	// While the write side is in reset the pointer reads as 0 straight away,
	// so entry 0 keeps being overwritten until release
	assign wr_addr = reset_n_write_side ? wr_ptr : '0;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			wr_ptr <= '0;
		else if (!reset_n_write_side)
			wr_ptr <= '0;
		else
			// Depth is a power of two, so the wrap is free
			wr_ptr <= wr_ptr + 1'b1;
	end

	// Capture data arrives every cycle whether or not a read is in flight
	always_ff @(posedge pll_afi_clk)
	begin
		fifo_mem[wr_addr] <= capture_data_i;
	end

	// **************************************************
	// Read side
	// **************************************************

	// Sequencer reset clears the read pointer on the same edge, which lets it
	// slip this group against the others during calibration
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			rd_ptr <= '0;
		else if (seq_read_fifo_reset_i)
			rd_ptr <= '0;
		else if (read_enable_i)
			rd_ptr <= rd_ptr + 1'b1;
	end

	// Output holds the last popped entry between reads
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			read_data_o <= '0;
		else if (read_enable_i)
			read_data_o <= fifo_mem[rd_ptr];
	end

endmodule

`default_nettype wire

// File: verilog/read_latency_fifo.sv
/*
 * Delays the controller's read enables by the calibrated read latency.
 * The full enable pops the group FIFOs and the data enable drives AFI valid.
 */

`timescale 1ns/1ps
`default_nettype none

module read_latency_fifo (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire afi_rdata_en_i,
	input wire afi_rdata_en_full_i,
	input wire read_datapath_pkg::latency_count_t latency_count_i,
	output logic read_enable_o,
	output read_datapath_pkg::afi_phase_t afi_rdata_valid_o
);

	import read_datapath_pkg::*;

	// Bit n holds the enable that was sampled n edges ago
	logic [MAX_READ_LATENCY-1:0] valid_shifter;
	logic [MAX_READ_LATENCY-1:0] full_shifter;
	logic read_valid;

	// **************************************************
	// Enable shift registers
	// **************************************************

	// Both enables march through their own register, one stage per AFI cycle
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			valid_shifter <= '0;
			full_shifter <= '0;
		end
		else
		begin
			valid_shifter <= {valid_shifter[MAX_READ_LATENCY-2:0], afi_rdata_en_i};
			full_shifter <= {full_shifter[MAX_READ_LATENCY-2:0], afi_rdata_en_full_i};
		end
	end

	// **************************************************
	// Tap selection
	// **************************************************

	// The tap at the latency count is registered one edge after the enable
	// reaches it, so the pop strobe arrives L+1 cycles after the request
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_enable_o <= 1'b0;
			read_valid <= 1'b0;
		end
		else
		begin
			read_enable_o <= full_shifter[latency_count_i];
			read_valid <= valid_shifter[latency_count_i];
		end
	end

	// The group FIFOs load their output registers on the edge after the pop,
	// so valid needs one more stage to line up with the popped data
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			afi_rdata_valid_o <= '0;
		else
			// Both AFI phases carry the same valid at half rate
			afi_rdata_valid_o <= {AFI_RATE_RATIO{read_valid}};
	end

endmodule

`default_nettype wire
